// ==== project.f ====
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/control_fsm.sv
verilog/reg_file.sv
verilog/alu_shift.sv
verilog/cpu_top.sv
tb/cpu_checker.sv
tb/cpu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb \
    -f project.f --Mdir "$BUILD_DIR" -o cpu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/cpu_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if grep -qx "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

// ==== tb/cpu_checker.sv ====
`timescale 1ns/1ns

module cpu_checker (
    input logic                           clk,
    input logic                           Rst,
    input logic                           reg_we,
    input logic [cpu_pkg::REG_ADDR_W-1:0] reg_waddr
);
    import cpu_pkg::*;

    // Write strobe is a single-cycle pulse
    single_cycle_we: assert property (@(posedge clk) disable iff (Rst) reg_we |=> !reg_we)
        else $error("reg_we stayed high for two consecutive cycles");

    quiet_in_reset: assert property (@(posedge clk) Rst |-> !reg_we)
        else $error("reg_we high while reset is asserted");

    // r15 is never a destination
    no_pc_write: assert property (@(posedge clk) disable iff (Rst) reg_we |-> reg_waddr != '1)
        else $error("register write addressed r15");

endmodule

bind cpu_top cpu_checker u_checker (
    .clk(clk),
    .Rst(Rst),
    .reg_we(reg_we),
    .reg_waddr(reg_waddr)
);

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;
    import cpu_pkg::*;

    logic                   clk;
    logic                   Rst;
    logic [XLEN-1:0]        inst;
    logic [IMEM_ADDR_W-1:0] inst_addr;
    logic                   reg_we;
    logic [REG_ADDR_W-1:0]  reg_waddr;
    logic [XLEN-1:0]        reg_wdata;
    logic [3:0]             nzcv;

    logic [XLEN-1:0]       imem [2**IMEM_ADDR_W];
    logic [XLEN-1:0]       prog [2**IMEM_ADDR_W];
    string                 prog_name [2**IMEM_ADDR_W];
    int                    prog_len;
    string                 exp_name [2**IMEM_ADDR_W];
    logic [REG_ADDR_W-1:0] exp_reg [2**IMEM_ADDR_W];
    logic [XLEN-1:0]       exp_val [2**IMEM_ADDR_W];
    logic [3:0]            exp_flags [2**IMEM_ADDR_W];
    int                    exp_count;
    logic [31:0]           rng;

    cpu_top dut (
        .clk(clk), .Rst(Rst), .inst(inst), .inst_addr(inst_addr), .reg_we(reg_we),
        .reg_waddr(reg_waddr), .reg_wdata(reg_wdata), .nzcv(nzcv)
    );

    // Instruction memory answers combinationally
    assign inst = imem[inst_addr];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic logic [XLEN-1:0] dp_reg_word(cond_e c, alu_op_e op, logic s, int rd,
                                                    int rn, int rm, shift_e ty, int amt);
        return {c, 3'b000, op, s, 4'(rn), 4'(rd), 5'(amt), ty, 1'b0, 4'(rm)};
    endfunction

    function automatic logic [XLEN-1:0] dp_imm_word(cond_e c, alu_op_e op, logic s, int rd,
                                                    int rn, logic [3:0] rot, logic [7:0] imm8);
        return {c, 3'b001, op, s, 4'(rn), 4'(rd), rot, imm8};
    endfunction

    function automatic logic [XLEN-1:0] branch_word(cond_e c, int off);
        return {c, 3'b101, 1'b0, 24'(off)};
    endfunction

    // Odd codes invert the test of their even partner
    function automatic logic cond_holds(logic [3:0] c, logic [3:0] f);
        logic t;
        case (c[3:1])
            3'd0: t = f[2];
            3'd1: t = f[1];
            3'd2: t = f[3];
            3'd3: t = f[0];
            3'd4: t = f[1] && !f[2];
            3'd5: t = f[3] == f[0];
            3'd6: t = !f[2] && (f[3] == f[0]);
            default: t = 1'b1;
        endcase
        return (c[3:1] == 3'd7) ? !c[0] : (t ^ c[0]);
    endfunction

    // Result is {carry, value}
    // One bit per step so a zero amount keeps the carry
    function automatic logic [XLEN:0] operand2(logic [XLEN-1:0] w, logic [XLEN-1:0] rmv,
                                              logic c);
        logic [XLEN-1:0] v;
        logic [1:0]      ty;
        int              n;
        v  = w[25] ? {24'h0, w[7:0]} : rmv;
        ty = w[25] ? 2'd3 : w[6:5];
        n  = w[25] ? 2 * int'(w[11:8]) : int'(w[11:7]);
        repeat (n) begin
            c = (ty == 2'd0) ? v[XLEN-1] : v[0];
            case (ty)
                2'd0: v = v << 1;
                2'd1: v = v >> 1;
                2'd2: v = {v[XLEN-1], v[XLEN-1:1]};
                default: v = {v[0], v[XLEN-1:1]};
            endcase
        end
        return {c, v};
    endfunction

    // Returns {overflow, carry, sum}
    function automatic logic [XLEN+1:0] add_with_carry(logic [XLEN-1:0] x, logic [XLEN-1:0] y,
                                                      logic ci);
        logic [63:0]     us;
        logic [63:0]     ss;
        logic [XLEN-1:0] r;
        us = {32'h0, x} + {32'h0, y} + {63'h0, ci};
        ss = {{32{x[31]}}, x} + {{32{y[31]}}, y} + {63'h0, ci};
        r  = us[XLEN-1:0];
        return {ss != {{32{r[31]}}, r}, us[XLEN], r};
    endfunction

    task automatic add_word(string name, logic [XLEN-1:0] w);
        prog[prog_len] = w;
        prog_name[prog_len] = name;
        prog_len++;
    endtask

    task automatic build_program();
        prog_len = 0;
        rng = xorshift32(rng);
        add_word("mov_rot_imm", dp_imm_word(CC_AL, OP_MOV, 1'b0, 1, 0, rng[11:8], rng[7:0]));
        rng = xorshift32(rng);
        add_word("mvns_rot_imm", dp_imm_word(CC_AL, OP_MVN, 1'b1, 2, 0, rng[11:8], rng[7:0]));
        rng = xorshift32(rng);
        add_word("movs_imm8", dp_imm_word(CC_AL, OP_MOV, 1'b1, 3, 0, 4'd0, rng[7:0]));
        add_word("adds_lsl", dp_reg_word(CC_AL, OP_ADD, 1'b1, 4, 1, 2, SH_LSL, 3));
        add_word("subs_lsr", dp_reg_word(CC_AL, OP_SUB, 1'b1, 5, 1, 3, SH_LSR, 5));
        add_word("rsbs_asr", dp_reg_word(CC_AL, OP_RSB, 1'b1, 6, 2, 1, SH_ASR, 7));
        add_word("adcs_ror", dp_reg_word(CC_AL, OP_ADC, 1'b1, 7, 3, 4, SH_ROR, 11));
        add_word("sbcs_noshift", dp_reg_word(CC_AL, OP_SBC, 1'b1, 8, 4, 5, SH_LSL, 0));
        add_word("ands_lsl", dp_reg_word(CC_AL, OP_AND, 1'b1, 9, 1, 2, SH_LSL, 1));
        add_word("orrs_lsr", dp_reg_word(CC_AL, OP_ORR, 1'b1, 10, 3, 5, SH_LSR, 3));
        add_word("eors_asr", dp_reg_word(CC_AL, OP_EOR, 1'b1, 11, 6, 7, SH_ASR, 2));
        add_word("bics_ror", dp_reg_word(CC_AL, OP_BIC, 1'b1, 12, 8, 9, SH_ROR, 4));
        add_word("rsc_lsl", dp_reg_word(CC_AL, OP_RSC, 1'b0, 13, 2, 4, SH_LSL, 2));
        add_word("cmp_equal", dp_reg_word(CC_AL, OP_CMP, 1'b1, 0, 1, 1, SH_LSL, 0));
        add_word("moveq_taken", dp_imm_word(CC_EQ, OP_MOV, 1'b0, 0, 0, 4'd0, 8'h01));
        add_word("movne_skipped", dp_imm_word(CC_NE, OP_MOV, 1'b0, 0, 0, 4'd0, 8'h02));
        add_word("cmn_regs", dp_reg_word(CC_AL, OP_CMN, 1'b1, 0, 4, 5, SH_LSL, 0));
        add_word("tst_zero", dp_imm_word(CC_AL, OP_TST, 1'b1, 0, 3, 4'd0, 8'h00));
        add_word("addeq_imm", dp_imm_word(CC_EQ, OP_ADD, 1'b0, 14, 1, 4'd0, 8'h05));
        add_word("teq_equal", dp_reg_word(CC_AL, OP_TEQ, 1'b1, 0, 1, 1, SH_LSL, 0));
        add_word("subne_skipped", dp_reg_word(CC_NE, OP_SUB, 1'b0, 14, 1, 2, SH_LSL, 0));
        add_word("mov_never", dp_imm_word(CC_NV, OP_MOV, 1'b0, 0, 0, 4'd0, 8'h55));
        add_word("class_undef", 32'hE600_0010);
        add_word("rd_pc_undef", dp_imm_word(CC_AL, OP_MOV, 1'b0, 15, 0, 4'd0, 8'h01));
        add_word("rn_pc_undef", dp_reg_word(CC_AL, OP_ADD, 1'b0, 1, 15, 2, SH_LSL, 0));
        add_word("rm_pc_undef", dp_reg_word(CC_AL, OP_ADD, 1'b0, 1, 2, 15, SH_LSL, 0));
        add_word("reg_shift_undef", dp_reg_word(CC_AL, OP_ADD, 1'b0, 1, 1, 2, SH_LSL, 0) | 32'h10);
        add_word("bl_undef", branch_word(CC_AL, 1) | 32'h0100_0000);
        add_word("b_forward", branch_word(CC_AL, 2));
        add_word("mov_jumped_a", dp_imm_word(CC_AL, OP_MOV, 1'b0, 0, 0, 4'd0, 8'hAA));
        add_word("mov_jumped_b", dp_imm_word(CC_AL, OP_MOV, 1'b0, 0, 0, 4'd0, 8'hBB));
        add_word("mov_target", dp_imm_word(CC_AL, OP_MOV, 1'b0, 13, 0, 4'd0, 8'h77));
        add_word("bne_not_taken", branch_word(CC_NE, 1));
        add_word("beq_taken", branch_word(CC_EQ, 1));
        add_word("mov_after_beq", dp_imm_word(CC_AL, OP_MOV, 1'b0, 0, 0, 4'd0, 8'hCC));
        add_word("mov_reg_lsl", dp_reg_word(CC_AL, OP_MOV, 1'b0, 12, 0, 13, SH_LSL, 4));
        add_word("cmp_random", dp_reg_word(CC_AL, OP_CMP, 1'b1, 0, 1, 2, SH_LSL, 0));
        add_word("movge", dp_imm_word(CC_GE, OP_MOV, 1'b0, 0, 0, 4'd0, 8'h11));
        add_word("movlt", dp_imm_word(CC_LT, OP_MOV, 1'b0, 0, 0, 4'd0, 8'h22));
        add_word("adds_final", dp_reg_word(CC_AL, OP_ADD, 1'b1, 14, 14, 13, SH_LSL, 0));
    endtask

    // Walks the program in order and records every expected register write
    task automatic model_program();
        logic [XLEN-1:0] regs [NUM_REGS];
        logic [XLEN-1:0] w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] r;
        logic [XLEN:0]   op2;
        logic [XLEN+1:0] acv;
        logic [3:0]      f;
        logic            arith;
        logic            compare;
        logic            dp;
        alu_op_e         op;
        int              pc;
        int              here;
        pc = 0;
        f = 4'b0000;
        exp_count = 0;
        for (int i = 0; i < NUM_REGS; i++)
            regs[i] = '0;
        while (pc < prog_len) begin
            here = pc;
            w = prog[pc];
            pc++;
            op = alu_op_e'(w[24:21]);
            compare = op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};
            dp = (w[27:25] == 3'b001) || ((w[27:25] == 3'b000) && !w[4]);
            if (!cond_holds(w[31:28], f))
                continue;
            if ((w[27:25] == 3'b101) && !w[24]) begin
                // Offset counts words from the one after the branch
                pc = pc + int'($signed(w[23:0]));
                continue;
            end
            if (!dp || (w[19:16] == 4'hF) || (w[15:12] == 4'hF))
                continue;
            if (((w[27:25] == 3'b000) && (w[3:0] == 4'hF)) || (compare && !w[20]))
                continue;
            a   = regs[w[19:16]];
            op2 = operand2(w, (w[3:0] != 4'hF) ? regs[w[3:0]] : '0, f[1]);
            b   = op2[XLEN-1:0];
            acv = '0;
            arith = 1'b1;
            case (op)
                OP_ADD, OP_CMN: acv = add_with_carry(a, b, 1'b0);
                OP_ADC: acv = add_with_carry(a, b, f[1]);
                OP_SUB, OP_CMP: acv = add_with_carry(a, ~b, 1'b1);
                OP_SBC: acv = add_with_carry(a, ~b, f[1]);
                OP_RSB: acv = add_with_carry(b, ~a, 1'b1);
                OP_RSC: acv = add_with_carry(b, ~a, f[1]);
                default: arith = 1'b0;
            endcase
            case (op)
                OP_AND, OP_TST: r = a & b;
                OP_EOR, OP_TEQ: r = a ^ b;
                OP_ORR: r = a | b;
                OP_MOV: r = b;
                OP_BIC: r = a & ~b;
                OP_MVN: r = ~b;
                default: r = acv[XLEN-1:0];
            endcase
            if (w[20])
                f = {r[XLEN-1], r == '0, arith ? acv[XLEN] : op2[XLEN], arith ? acv[XLEN+1] : f[0]};
            if (!compare) begin
                exp_name[exp_count]  = prog_name[here];
                exp_reg[exp_count]   = w[15:12];
                exp_val[exp_count]   = r;
                exp_flags[exp_count] = f;
                exp_count++;
                regs[w[15:12]] = r;
            end
        end
    endtask

    task automatic report_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic check_addr(string name, logic [IMEM_ADDR_W-1:0] expected,
                              logic [IMEM_ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: inst_addr expected %0h, actual %0h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_reg(string name, logic [REG_ADDR_W-1:0] expected,
                             logic [REG_ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: register expected r%0d, actual r%0d", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_data(string name, logic [XLEN-1:0] expected, logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: data expected %08h, actual %08h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_flags(string name, logic [3:0] expected, logic [3:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: NZCV expected %04b, actual %04b", name, expected, actual);
            report_failure();
        end
    endtask

    initial begin
        int idx;
        int cycles;
        int limit;
        Rst = 1'b1;
        rng = 32'd84997;
        build_program();
        model_program();
        // Unused words carry the NV condition and never execute
        for (int i = 0; i < 2**IMEM_ADDR_W; i++)
            imem[i] = (i < prog_len) ? prog[i] : {4'hF, 22'h0, 6'(i)};
        limit = 4 * prog_len + 20;

        repeat (8) @(posedge clk);
        check_addr("reset_pc", '0, inst_addr);
        #1;
        Rst = 1'b0;

        idx = 0;
        cycles = 0;
        while ((idx < exp_count) && (cycles < limit)) begin
            @(negedge clk);
            cycles++;
            if (reg_we) begin
                check_reg(exp_name[idx], exp_reg[idx], reg_waddr);
                check_data(exp_name[idx], exp_val[idx], reg_wdata);
                check_flags(exp_name[idx], exp_flags[idx], nzcv);
                idx++;
            end
        end

        if (idx == exp_count) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            $display("Timed out after %0d cycles, only %0d of %0d register writes arrived",
                     cycles, idx, exp_count);
            report_failure();
        end
    end

endmodule

// ==== verilog/alu_shift.sv ====
`timescale 1ns/1ns

module alu_shift (
    input  logic                     clk,
    input  logic                     Rst,
    input  logic                     lf,
    input  logic                     set_flags,
    input  logic [cpu_pkg::XLEN-1:0] ir,
    input  logic                     alu_a_sel,
    input  logic                     alu_b_sel,
    input  logic [cpu_pkg::XLEN-1:0] op_a,
    input  logic [cpu_pkg::XLEN-1:0] op_b,
    input  logic [cpu_pkg::XLEN-1:0] pc,
    output logic [cpu_pkg::XLEN-1:0] result,
    output logic [3:0]               nzcv
);
    import cpu_pkg::*;

    logic [XLEN-1:0]   sh_data;
    logic [4:0]        sh_amt;
    shift_e            sh_type;
    logic [XLEN:0]     lsl_ext;
    logic [XLEN:0]     lsr_ext;
    logic [XLEN:0]     asr_ext;
    logic [2*XLEN-1:0] ror_ext;
    logic [XLEN-1:0]   sh_out;
    logic              sh_c;
    logic [XLEN-1:0]   br_offset;
    logic [XLEN-1:0]   alu_a;
    logic [XLEN-1:0]   alu_b;
    alu_op_e           op;
    logic [XLEN-1:0]   add_x;
    logic [XLEN-1:0]   add_y;
    logic              add_cin;
    logic              arith;
    logic [XLEN:0]     sum;
    logic [XLEN-1:0]   alu_f;
    logic              alu_c;
    logic              alu_v;

    // I bit picks rotated imm8 over shifted rm
    always_comb begin
        if (ir[CLASS_LO]) begin
            sh_data = {{(XLEN-8){1'b0}}, ir[IMM8_HI:IMM8_LO]};
            sh_amt  = {ir[ROT_HI:ROT_LO], 1'b0};
            sh_type = SH_ROR;
        end else begin
            sh_data = op_b;
            sh_amt  = ir[SHAMT_HI:SHAMT_LO];
            sh_type = shift_e'(ir[SHTYPE_HI:SHTYPE_LO]);
        end
    end

    // Extra bit catches the last bit shifted out
    assign lsl_ext = {1'b0, sh_data} << sh_amt;
    assign lsr_ext = {sh_data, 1'b0} >> sh_amt;
    assign asr_ext = $signed({sh_data, 1'b0}) >>> sh_amt;
    assign ror_ext = {sh_data, sh_data} >> sh_amt;

    always_comb begin
        sh_out = sh_data;
        sh_c   = nzcv[1];
        if (sh_amt != '0) begin
            case (sh_type)
                SH_LSL: {sh_c, sh_out} = lsl_ext;
                SH_LSR: {sh_out, sh_c} = lsr_ext;
                SH_ASR: {sh_out, sh_c} = asr_ext;
                SH_ROR: begin
                    sh_out = ror_ext[XLEN-1:0];
                    sh_c   = ror_ext[XLEN-1];
                end
                default: sh_out = sh_data;
            endcase
        end
    end

    assign br_offset = {{(XLEN-26){ir[IMM24_HI]}}, ir[IMM24_HI:IMM24_LO], 2'b00};
    assign alu_a     = alu_a_sel ? pc : op_a;
    assign alu_b     = alu_b_sel ? br_offset : sh_out;
    assign op        = alu_b_sel ? OP_ADD : alu_op_e'(ir[OPC_HI:OPC_LO]);

    // Adder inputs, subtraction as inverted operand plus carry
    always_comb begin
        add_x   = alu_a;
        add_y   = alu_b;
        add_cin = 1'b0;
        arith   = 1'b1;
        case (op)
            OP_ADD, OP_CMN: arith = 1'b1;
            OP_ADC: add_cin = nzcv[1];
            OP_SUB, OP_CMP: begin
                add_y   = ~alu_b;
                add_cin = 1'b1;
            end
            OP_SBC: begin
                add_y   = ~alu_b;
                add_cin = nzcv[1];
            end
            OP_RSB: begin
                add_x   = alu_b;
                add_y   = ~alu_a;
                add_cin = 1'b1;
            end
            OP_RSC: begin
                add_x   = alu_b;
                add_y   = ~alu_a;
                add_cin = nzcv[1];
            end
            default: arith = 1'b0;
        endcase
    end

    assign sum = {1'b0, add_x} + {1'b0, add_y} + {{XLEN{1'b0}}, add_cin};

    always_comb begin
        case (op)
            OP_AND, OP_TST: alu_f = alu_a & alu_b;
            OP_EOR, OP_TEQ: alu_f = alu_a ^ alu_b;
            OP_ORR:         alu_f = alu_a | alu_b;
            OP_MOV:         alu_f = alu_b;
            OP_BIC:         alu_f = alu_a & ~alu_b;
            OP_MVN:         alu_f = ~alu_b;
            default:        alu_f = sum[XLEN-1:0];
        endcase
    end

    assign alu_c = arith ? sum[XLEN] : sh_c;
    assign alu_v = arith ? ((add_x[XLEN-1] == add_y[XLEN-1]) && (sum[XLEN-1] != add_x[XLEN-1]))
                         : nzcv[0];

    always_ff @(posedge clk) begin
        if (lf)
            result <= alu_f;
    end

    // Flags change only for S-bit instructions
    always_ff @(posedge clk or posedge Rst) begin
        if (Rst)
            nzcv <= '0;
        else if (lf && set_flags && ir[S_BIT])
            nzcv <= {alu_f[XLEN-1], alu_f == '0, alu_c, alu_v};
    end

endmodule

// ==== verilog/control_fsm.sv ====
`timescale 1ns/1ns

module control_fsm (
    input  logic               clk,
    input  logic               Rst,
    input  cpu_pkg::inst_fmt_e inst_fmt,
    input  logic               undef,
    input  logic               cond_pass,
    input  cpu_pkg::alu_op_e   opcode,
    output logic               write_pc,
    output logic               write_ir,
    output logic               pc_sel,
    output logic               la_lb,
    output logic               lf,
    output logic               set_flags,
    output logic               reg_we,
    output logic               alu_a_sel,
    output logic               alu_b_sel
);
    import cpu_pkg::*;

    state_e state;
    state_e next_state;
    logic   writes_rd;

    // Compares only touch the flags
    assign writes_rd = !(opcode inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN});

    always_ff @(posedge clk or posedge Rst) begin
        if (Rst)
            state <= ST_IDLE;
        else
            state <= next_state;
    end

    always_comb begin
        case (state)
            ST_IDLE:   next_state = ST_FETCH;
            ST_FETCH:  next_state = ST_DECODE;
            ST_DECODE: begin
                if (!cond_pass || undef)
                    next_state = ST_FETCH;
                else if (inst_fmt == FMT_BRANCH)
                    next_state = ST_BR_CALC;
                else
                    next_state = ST_EXEC;
            end
            ST_EXEC:     next_state = ST_WRITE;
            ST_WRITE:    next_state = ST_FETCH;
            ST_BR_CALC:  next_state = ST_BR_WRITE;
            ST_BR_WRITE: next_state = ST_FETCH;
            default:     next_state = ST_IDLE;
        endcase
    end

    // Strobes follow the next state so they are valid for the whole state
    always_ff @(posedge clk or posedge Rst) begin
        if (Rst) begin
            write_pc  <= 1'b0;
            write_ir  <= 1'b0;
            pc_sel    <= 1'b0;
            la_lb     <= 1'b0;
            lf        <= 1'b0;
            set_flags <= 1'b0;
            reg_we    <= 1'b0;
            alu_a_sel <= 1'b0;
            alu_b_sel <= 1'b0;
        end else begin
            write_pc  <= 1'b0;
            write_ir  <= 1'b0;
            pc_sel    <= 1'b0;
            la_lb     <= 1'b0;
            lf        <= 1'b0;
            set_flags <= 1'b0;
            reg_we    <= 1'b0;
            alu_a_sel <= 1'b0;
            alu_b_sel <= 1'b0;
            case (next_state)
                ST_FETCH: begin
                    write_pc <= 1'b1;
                    write_ir <= 1'b1;
                end
                ST_DECODE: la_lb <= 1'b1;
                ST_EXEC: begin
                    lf        <= 1'b1;
                    set_flags <= 1'b1;
                end
                ST_WRITE: reg_we <= writes_rd;
                ST_BR_CALC: begin
                    // PC plus scaled offset
                    lf        <= 1'b1;
                    alu_a_sel <= 1'b1;
                    alu_b_sel <= 1'b1;
                end
                ST_BR_WRITE: begin
                    write_pc <= 1'b1;
                    pc_sel   <= 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 4;
    localparam int NUM_REGS    = 15;
    localparam int IMEM_ADDR_W = 6;
    localparam int PC_STEP     = 4;

    // Instruction word fields
    localparam int COND_HI       = 31;
    localparam int COND_LO       = 28;
    localparam int CLASS_HI      = 27;
    localparam int CLASS_LO      = 25;
    localparam int OPC_HI        = 24;
    localparam int OPC_LO        = 21;
    localparam int S_BIT         = 20;
    localparam int RN_HI         = 19;
    localparam int RN_LO         = 16;
    localparam int RD_HI         = 15;
    localparam int RD_LO         = 12;
    localparam int SHAMT_HI      = 11;
    localparam int SHAMT_LO      = 7;
    localparam int SHTYPE_HI     = 6;
    localparam int SHTYPE_LO     = 5;
    localparam int RM_HI         = 3;
    localparam int RM_LO         = 0;
    localparam int ROT_HI        = 11;
    localparam int ROT_LO        = 8;
    localparam int IMM8_HI       = 7;
    localparam int IMM8_LO       = 0;
    localparam int IMM24_HI      = 23;
    localparam int IMM24_LO      = 0;
    localparam int REG_SHIFT_BIT = 4;
    localparam int LINK_BIT      = 24;

    typedef enum logic [3:0] {
        OP_AND, OP_EOR, OP_SUB, OP_RSB, OP_ADD, OP_ADC, OP_SBC, OP_RSC,
        OP_TST, OP_TEQ, OP_CMP, OP_CMN, OP_ORR, OP_MOV, OP_BIC, OP_MVN
    } alu_op_e;

    typedef enum logic [1:0] {SH_LSL, SH_LSR, SH_ASR, SH_ROR} shift_e;

    typedef enum logic [3:0] {
        CC_EQ, CC_NE, CC_CS, CC_CC, CC_MI, CC_PL, CC_VS, CC_VC,
        CC_HI, CC_LS, CC_GE, CC_LT, CC_GT, CC_LE, CC_AL, CC_NV
    } cond_e;

    typedef enum logic [1:0] {FMT_DP_REG, FMT_DP_IMM, FMT_BRANCH, FMT_UNDEF} inst_fmt_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC, ST_WRITE, ST_BR_CALC, ST_BR_WRITE
    } state_e;

endpackage

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
    input  logic                            clk,
    input  logic                            Rst,
    input  logic [cpu_pkg::XLEN-1:0]        inst,
    output logic [cpu_pkg::IMEM_ADDR_W-1:0] inst_addr,
    output logic                            reg_we,
    output logic [cpu_pkg::REG_ADDR_W-1:0]  reg_waddr,
    output logic [cpu_pkg::XLEN-1:0]        reg_wdata,
    output logic [3:0]                      nzcv
);
    import cpu_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic            cond_pass;
    inst_fmt_e       inst_fmt;
    logic            undef;
    alu_op_e         opcode;
    logic            write_pc;
    logic            write_ir;
    logic            pc_sel;
    logic            la_lb;
    logic            lf;
    logic            set_flags;
    logic            alu_a_sel;
    logic            alu_b_sel;

    // Word address, byte offset dropped
    assign inst_addr = pc[IMEM_ADDR_W+1:2];
    assign opcode    = alu_op_e'(ir[OPC_HI:OPC_LO]);
    assign reg_waddr = ir[RD_HI:RD_LO];
    assign reg_wdata = result;

    fetch_unit u_fetch (
        .clk(clk), .Rst(Rst), .inst(inst), .write_ir(write_ir), .write_pc(write_pc),
        .pc_sel(pc_sel), .result(result), .nzcv(nzcv), .pc(pc), .ir(ir),
        .cond_pass(cond_pass)
    );

    inst_decoder u_decoder (.ir(ir), .inst_fmt(inst_fmt), .undef(undef));

    control_fsm u_ctrl (
        .clk(clk), .Rst(Rst), .inst_fmt(inst_fmt), .undef(undef), .cond_pass(cond_pass),
        .opcode(opcode), .write_pc(write_pc), .write_ir(write_ir), .pc_sel(pc_sel),
        .la_lb(la_lb), .lf(lf), .set_flags(set_flags), .reg_we(reg_we),
        .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel)
    );

    reg_file u_regs (
        .clk(clk), .Rst(Rst), .la_lb(la_lb), .reg_we(reg_we),
        .raddr_a(ir[RN_HI:RN_LO]), .raddr_b(ir[RM_HI:RM_LO]), .waddr(ir[RD_HI:RD_LO]),
        .wdata(result), .rdata_a(rdata_a), .rdata_b(rdata_b)
    );

    alu_shift u_alu (
        .clk(clk), .Rst(Rst), .lf(lf), .set_flags(set_flags), .ir(ir),
        .alu_a_sel(alu_a_sel), .alu_b_sel(alu_b_sel), .op_a(rdata_a), .op_b(rdata_b),
        .pc(pc), .result(result), .nzcv(nzcv)
    );

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit (
    input  logic                     clk,
    input  logic                     Rst,
    input  logic [cpu_pkg::XLEN-1:0] inst,
    input  logic                     write_ir,
    input  logic                     write_pc,
    input  logic                     pc_sel,
    input  logic [cpu_pkg::XLEN-1:0] result,
    input  logic [3:0]               nzcv,
    output logic [cpu_pkg::XLEN-1:0] pc,
    output logic [cpu_pkg::XLEN-1:0] ir,
    output logic                     cond_pass
);
    import cpu_pkg::*;

    cond_e cond;
    logic  n_f;
    logic  z_f;
    logic  c_f;
    logic  v_f;

    always_ff @(posedge clk or posedge Rst) begin
        if (Rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            // Branch target comes back through the ALU result
            if (write_pc)
                pc <= pc_sel ? result : pc + XLEN'(PC_STEP);
            if (write_ir)
                ir <= inst;
        end
    end

    assign cond = cond_e'(ir[COND_HI:COND_LO]);
    assign {n_f, z_f, c_f, v_f} = nzcv;

    always_comb begin
        case (cond)
            CC_EQ: cond_pass = z_f;
            CC_NE: cond_pass = !z_f;
            CC_CS: cond_pass = c_f;
            CC_CC: cond_pass = !c_f;
            CC_MI: cond_pass = n_f;
            CC_PL: cond_pass = !n_f;
            CC_VS: cond_pass = v_f;
            CC_VC: cond_pass = !v_f;
            CC_HI: cond_pass = c_f && !z_f;
            CC_LS: cond_pass = !c_f || z_f;
            CC_GE: cond_pass = n_f == v_f;
            CC_LT: cond_pass = n_f != v_f;
            CC_GT: cond_pass = !z_f && (n_f == v_f);
            CC_LE: cond_pass = z_f || (n_f != v_f);
            CC_AL: cond_pass = 1'b1;
            CC_NV: cond_pass = 1'b0;
            default: cond_pass = 1'b0;
        endcase
    end

endmodule

// ==== verilog/inst_decoder.sv ====
`timescale 1ns/1ns

module inst_decoder (
    input  logic [cpu_pkg::XLEN-1:0] ir,
    output cpu_pkg::inst_fmt_e       inst_fmt,
    output logic                     undef
);
    import cpu_pkg::*;

    logic [2:0]            cls;
    logic [REG_ADDR_W-1:0] rn;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rm;
    alu_op_e               opc;
    logic                  is_dp;
    logic                  uses_pc;
    logic                  cmp_no_s;

    assign cls = ir[CLASS_HI:CLASS_LO];
    assign rn  = ir[RN_HI:RN_LO];
    assign rd  = ir[RD_HI:RD_LO];
    assign rm  = ir[RM_HI:RM_LO];
    assign opc = alu_op_e'(ir[OPC_HI:OPC_LO]);

    always_comb begin
        case (cls)
            3'b000:  inst_fmt = ir[REG_SHIFT_BIT] ? FMT_UNDEF : FMT_DP_REG;
            3'b001:  inst_fmt = FMT_DP_IMM;
            3'b101:  inst_fmt = ir[LINK_BIT] ? FMT_UNDEF : FMT_BRANCH;
            default: inst_fmt = FMT_UNDEF;
        endcase
    end

    assign is_dp = (inst_fmt == FMT_DP_REG) || (inst_fmt == FMT_DP_IMM);

    // No r15 access, rm only exists in the register form
    assign uses_pc = (rd == '1) || (rn == '1) || ((inst_fmt == FMT_DP_REG) && (rm == '1));

    // Compare opcodes without S belong to other instruction groups
    assign cmp_no_s = (opc inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN}) && !ir[S_BIT];

    assign undef = (inst_fmt == FMT_UNDEF) || (is_dp && (uses_pc || cmp_no_s));

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic                           clk,
    input  logic                           Rst,
    input  logic                           la_lb,
    input  logic                           reg_we,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_a,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr_b,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [cpu_pkg::XLEN-1:0]       wdata,
    output logic [cpu_pkg::XLEN-1:0]       rdata_a,
    output logic [cpu_pkg::XLEN-1:0]       rdata_b
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge Rst) begin
        if (Rst) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (reg_we && (waddr < NUM_REGS)) begin
            regs[waddr] <= wdata;
        end
    end

    // Operand latches, loaded in DECODE
    always_ff @(posedge clk) begin
        if (la_lb) begin
            rdata_a <= (raddr_a < NUM_REGS) ? regs[raddr_a] : '0;
            rdata_b <= (raddr_b < NUM_REGS) ? regs[raddr_b] : '0;
        end
    end

endmodule
